/* src/radio_ctrl_pkg.sv */
package radio_ctrl_pkg;

   ////////////////////
   // Word types

   typedef logic [35:0] stream_word_t;
   typedef logic [7:0]  set_addr_t;
   typedef logic [31:0] set_data_t;
   typedef logic [63:0] vita_time_t;
   typedef logic [3:0]  rb_sel_t;

   // Framing flags in a stream word
   localparam int SOP_BIT = 32;
   localparam int EOP_BIT = 33;

   // Write request flag in the command header
   localparam int CMD_WRITE_BIT = 31;

   ////////////////////
   // Settings addresses

   localparam set_addr_t SR_MISC   = 8'd0;
   localparam set_addr_t SR_TIME64 = 8'd8;
   localparam set_addr_t SR_GPIO   = 8'd16;

   ////////////////////
   // Readback map

   localparam rb_sel_t RB_COMPAT  = 4'd0;
   localparam rb_sel_t RB_GPIO    = 4'd1;
   localparam rb_sel_t RB_CONFIG0 = 4'd2;
   localparam rb_sel_t RB_CONFIG1 = 4'd3;
   localparam rb_sel_t RB_TIME_HI = 4'd4;
   localparam rb_sel_t RB_TIME_LO = 4'd5;
   localparam rb_sel_t RB_PPS_HI  = 4'd6;
   localparam rb_sel_t RB_PPS_LO  = 4'd7;

   // Major in the upper half, minor in the lower half
   localparam set_data_t COMPAT_NUM = {16'd11, 16'd0};
   localparam set_data_t RB_UNUSED  = 32'hffff_ffff;

endpackage

/* src/stream_fifo.sv */
`timescale 1ns/1ns

module stream_fifo #(
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                         clk,
   input  logic                         rst_i,
   input  radio_ctrl_pkg::stream_word_t in_data_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   output radio_ctrl_pkg::stream_word_t out_data_o,
   output logic                         out_valid_o,
   input  logic                         out_ready_i
);
   import radio_ctrl_pkg::*;

   localparam int DEPTH = 2 ** DEPTH_LOG2;

   stream_word_t          mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic [DEPTH_LOG2:0]   count_next;
   logic                  do_write;
   logic                  do_read;

   assign do_write    = in_valid_i & in_ready_o;
   assign do_read     = out_valid_o & out_ready_i;
   assign out_valid_o = (count != '0);
   assign out_data_o  = mem[rd_ptr];

   always_comb begin
      count_next = count;
      if (do_write && !do_read) begin
         count_next = count + 1'b1;
      end else if (!do_write && do_read) begin
         count_next = count - 1'b1;
      end
   end

   // Ring storage
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= in_data_i;
      end
   end

   // Pointers, fill level, and ready low only when full
   always_ff @(posedge clk) begin
      if (rst_i) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         in_ready_o <= 1'b0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count      <= count_next;
         in_ready_o <= (count_next != DEPTH[DEPTH_LOG2:0]);
      end
   end

endmodule

/* src/ctrl_packet_engine.sv */
`timescale 1ns/1ns

module ctrl_packet_engine (
   input  logic                         clk,
   input  logic                         rst_i,
   input  radio_ctrl_pkg::stream_word_t in_data_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   output radio_ctrl_pkg::stream_word_t out_data_o,
   output logic                         out_valid_o,
   input  logic                         out_ready_i,
   output logic                         set_stb_o,
   output radio_ctrl_pkg::set_addr_t    set_addr_o,
   output radio_ctrl_pkg::set_data_t    set_data_o,
   output radio_ctrl_pkg::rb_sel_t      rb_sel_o,
   input  radio_ctrl_pkg::set_data_t    rb_data_i
);
   import radio_ctrl_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_HEADER,
      ST_DATA,
      ST_STROBE,
      ST_RB_WAIT,
      ST_REPLY_HDR,
      ST_REPLY_DATA,
      ST_DISCARD
   } state_t;

   state_t       state;
   logic         in_xfer;
   logic         in_sop;
   logic         in_eop;
   logic         hdr_ok;
   logic         data_ok;
   logic         write_q;
   logic         rb_wait_q;
   logic [7:0]   seq_q;
   set_data_t    rb_word;
   stream_word_t reply_hdr;
   stream_word_t reply_data;

   assign in_xfer = in_valid_i & in_ready_o;
   assign in_sop  = in_data_i[SOP_BIT];
   assign in_eop  = in_data_i[EOP_BIT];
   assign hdr_ok  = in_sop & ~in_eop;
   assign data_ok = ~in_sop & in_eop;

   // Command words only taken while no reply is pending
   assign in_ready_o  = (state == ST_HEADER) || (state == ST_DATA) || (state == ST_DISCARD);
   assign out_valid_o = (state == ST_REPLY_HDR) || (state == ST_REPLY_DATA);

   // Reply framing: header opens, data word closes
   assign reply_hdr  = {2'b00, 1'b0, 1'b1, 8'h00, seq_q, 4'h0, rb_sel_o, 8'h00};
   assign reply_data = {2'b00, 1'b1, 1'b0, rb_word};
   assign out_data_o = (state == ST_REPLY_DATA) ? reply_data : reply_hdr;

   always_ff @(posedge clk) begin
      if (rst_i) begin
         state     <= ST_IDLE;
         set_stb_o <= 1'b0;
         rb_wait_q <= 1'b0;
      end else begin
         set_stb_o <= 1'b0;
         case (state)
            ST_IDLE: begin
               if (in_valid_i) begin
                  state <= ST_HEADER;
               end
            end
            ST_HEADER: begin
               if (in_xfer) begin
                  if (hdr_ok) begin
                     state <= ST_DATA;
                  end else if (in_eop) begin
                     state <= ST_IDLE;
                  end else begin
                     state <= ST_DISCARD;
                  end
               end
            end
            ST_DATA: begin
               if (in_xfer) begin
                  if (data_ok) begin
                     state     <= ST_STROBE;
                     set_stb_o <= write_q;
                  end else if (in_eop) begin
                     state <= ST_IDLE;
                  end else begin
                     state <= ST_DISCARD;
                  end
               end
            end
            ST_STROBE: begin
               state     <= ST_RB_WAIT;
               rb_wait_q <= 1'b1;
            end
            // Two cycles so the readback register sees the write
            ST_RB_WAIT: begin
               rb_wait_q <= 1'b0;
               if (!rb_wait_q) begin
                  state <= ST_REPLY_HDR;
               end
            end
            ST_REPLY_HDR: begin
               if (out_ready_i) begin
                  state <= ST_REPLY_DATA;
               end
            end
            ST_REPLY_DATA: begin
               if (out_ready_i) begin
                  state <= ST_IDLE;
               end
            end
            ST_DISCARD: begin
               if (in_xfer && in_eop) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Command fields and the captured readback word
   always_ff @(posedge clk) begin
      if (state == ST_HEADER && in_xfer && hdr_ok) begin
         write_q    <= in_data_i[CMD_WRITE_BIT];
         seq_q      <= in_data_i[23:16];
         rb_sel_o   <= in_data_i[11:8];
         set_addr_o <= in_data_i[7:0];
      end
      if (state == ST_DATA && in_xfer) begin
         set_data_o <= in_data_i[31:0];
      end
      if (state == ST_RB_WAIT && !rb_wait_q) begin
         rb_word <= rb_data_i;
      end
   end

endmodule

/* src/core_registers.sv */
`timescale 1ns/1ns

module core_registers #(
   parameter radio_ctrl_pkg::set_addr_t BASE = radio_ctrl_pkg::SR_MISC
) (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   input  radio_ctrl_pkg::rb_sel_t    rb_sel_i,
   output radio_ctrl_pkg::set_data_t  rb_data_o,
   input  radio_ctrl_pkg::vita_time_t vita_time_i,
   input  radio_ctrl_pkg::vita_time_t vita_time_pps_i,
   input  radio_ctrl_pkg::set_data_t  gpio_readback_i,
   input  logic                       pps_i,
   output logic                       clock_sync_o
);
   import radio_ctrl_pkg::*;

   localparam set_addr_t ADDR_CONFIG0 = BASE;
   localparam set_addr_t ADDR_CONFIG1 = BASE + 8'd1;
   localparam set_addr_t ADDR_CSYNC   = BASE + 8'd2;

   set_data_t config_word0;
   set_data_t config_word1;
   logic      clock_sync_enb;
   logic      clock_sync_inv;

   always_ff @(posedge clk) begin
      if (set_stb_i && set_addr_i == ADDR_CONFIG0) begin
         config_word0 <= set_data_i;
      end
      if (set_stb_i && set_addr_i == ADDR_CONFIG1) begin
         config_word1 <= set_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         clock_sync_enb <= 1'b0;
         clock_sync_inv <= 1'b0;
      end else if (set_stb_i && set_addr_i == ADDR_CSYNC) begin
         clock_sync_enb <= set_data_i[0];
         clock_sync_inv <= set_data_i[1];
      end
   end

   // PPS passed straight out, optionally inverted
   assign clock_sync_o = clock_sync_enb & (pps_i ^ clock_sync_inv);

   ////////////////////
   // Readback mux

   always_ff @(posedge clk) begin
      case (rb_sel_i)
         RB_COMPAT:  rb_data_o <= COMPAT_NUM;
         RB_GPIO:    rb_data_o <= gpio_readback_i;
         RB_CONFIG0: rb_data_o <= config_word0;
         RB_CONFIG1: rb_data_o <= config_word1;
         RB_TIME_HI: rb_data_o <= vita_time_i[63:32];
         RB_TIME_LO: rb_data_o <= vita_time_i[31:0];
         RB_PPS_HI:  rb_data_o <= vita_time_pps_i[63:32];
         RB_PPS_LO:  rb_data_o <= vita_time_pps_i[31:0];
         default:    rb_data_o <= RB_UNUSED;
      endcase
   end

endmodule

/* src/time_64bit.sv */
`timescale 1ns/1ns

module time_64bit #(
   parameter radio_ctrl_pkg::set_addr_t BASE = radio_ctrl_pkg::SR_TIME64
) (
   input  logic                       clk,
   input  logic                       rst_i,
   input  logic                       set_stb_i,
   input  radio_ctrl_pkg::set_addr_t  set_addr_i,
   input  radio_ctrl_pkg::set_data_t  set_data_i,
   input  logic                       pps_i,
   output radio_ctrl_pkg::vita_time_t vita_time_o,
   output radio_ctrl_pkg::vita_time_t vita_time_pps_o
);
   import radio_ctrl_pkg::*;

   localparam set_addr_t ADDR_HI     = BASE;
   localparam set_addr_t ADDR_LO_NOW = BASE + 8'd1;
   localparam set_addr_t ADDR_LO_PPS = BASE + 8'd2;

   logic [2:0] pps_sync;
   logic       pps_edge;
   logic       load_armed;
   set_data_t  time_hi_pending;
   set_data_t  time_lo_pending;
   vita_time_t pps_load_value;

   // Two flops to sync, third one for edge detect
   assign pps_edge       = pps_sync[1] & ~pps_sync[2];
   assign pps_load_value = {time_hi_pending, time_lo_pending};

   always_ff @(posedge clk) begin
      if (set_stb_i && set_addr_i == ADDR_HI) begin
         time_hi_pending <= set_data_i;
      end
      if (set_stb_i && set_addr_i == ADDR_LO_PPS) begin
         time_lo_pending <= set_data_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         pps_sync        <= '0;
         load_armed      <= 1'b0;
         vita_time_o     <= '0;
         vita_time_pps_o <= '0;
      end else begin
         pps_sync <= {pps_sync[1:0], pps_i};

         if (set_stb_i && set_addr_i == ADDR_LO_NOW) begin
            vita_time_o <= {time_hi_pending, set_data_i};
         end else if (load_armed && pps_edge) begin
            vita_time_o <= pps_load_value;
         end else begin
            vita_time_o <= vita_time_o + 64'd1;
         end

         if (set_stb_i && set_addr_i == ADDR_LO_PPS) begin
            load_armed <= 1'b1;
         end else if (pps_edge) begin
            load_armed <= 1'b0;
         end

         // Latch sees the loaded value on an armed edge
         if (pps_edge) begin
            vita_time_pps_o <= load_armed ? pps_load_value : vita_time_o;
         end
      end
   end

endmodule

/* src/gpio_atr.sv */
`timescale 1ns/1ns

module gpio_atr #(
   parameter radio_ctrl_pkg::set_addr_t BASE       = radio_ctrl_pkg::SR_GPIO,
   parameter int                        GPIO_WIDTH = 32
) (
   input  logic                      clk,
   input  logic                      rst_i,
   input  logic                      set_stb_i,
   input  radio_ctrl_pkg::set_addr_t set_addr_i,
   input  radio_ctrl_pkg::set_data_t set_data_i,
   input  logic                      rx_run_i,
   input  logic                      tx_run_i,
   input  logic [GPIO_WIDTH-1:0]     gpio_i,
   output logic [GPIO_WIDTH-1:0]     gpio_o,
   output logic [GPIO_WIDTH-1:0]     gpio_oe_o,
   output radio_ctrl_pkg::set_data_t gpio_readback_o
);
   import radio_ctrl_pkg::*;

   localparam set_addr_t OFFSET_DDR = 8'd4;

   // Indexed by {tx, rx}: idle, rx-only, tx-only, full-duplex
   logic [GPIO_WIDTH-1:0] atr_word [4];
   set_addr_t             addr_offset;
   logic [1:0]            atr_state;

   assign addr_offset = set_addr_i - BASE;
   assign atr_state   = {tx_run_i, rx_run_i};

   // Output words, offsets 0 to 3 map onto the ATR states
   always_ff @(posedge clk) begin
      if (set_stb_i && addr_offset < OFFSET_DDR) begin
         atr_word[addr_offset[1:0]] <= set_data_i[GPIO_WIDTH-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst_i) begin
         gpio_oe_o <= '0;
         gpio_o    <= '0;
      end else begin
         if (set_stb_i && addr_offset == OFFSET_DDR) begin
            gpio_oe_o <= set_data_i[GPIO_WIDTH-1:0];
         end
         gpio_o <= atr_word[atr_state];
      end
   end

   // Pad sample for readback
   always_ff @(posedge clk) begin
      gpio_readback_o <= set_data_t'(gpio_i);
   end

endmodule

/* src/radio_ctrl_core.sv */
`timescale 1ns/1ns

module radio_ctrl_core #(
   parameter int GPIO_WIDTH     = 32,
   parameter int CTRL_FIFO_LOG2 = 4,
   parameter int RESP_FIFO_LOG2 = 4
) (
   input  logic                         clk,
   input  logic                         rst_i,
   input  radio_ctrl_pkg::stream_word_t ctrl_data_i,
   input  logic                         ctrl_valid_i,
   output logic                         ctrl_ready_o,
   output radio_ctrl_pkg::stream_word_t resp_data_o,
   output logic                         resp_valid_o,
   input  logic                         resp_ready_i,
   input  logic                         pps_i,
   input  logic                         rx_run_i,
   input  logic                         tx_run_i,
   input  logic [GPIO_WIDTH-1:0]        gpio_i,
   output logic [GPIO_WIDTH-1:0]        gpio_o,
   output logic [GPIO_WIDTH-1:0]        gpio_oe_o,
   output logic                         clock_sync_o
);
   import radio_ctrl_pkg::*;

   stream_word_t ctrl_int_data;
   logic         ctrl_int_valid;
   logic         ctrl_int_ready;
   stream_word_t resp_int_data;
   logic         resp_int_valid;
   logic         resp_int_ready;

   // Settings bus and readback
   logic         set_stb;
   set_addr_t    set_addr;
   set_data_t    set_data;
   rb_sel_t      rb_sel;
   set_data_t    rb_data;
   vita_time_t   vita_time;
   vita_time_t   vita_time_pps;
   set_data_t    gpio_readback;

   ////////////////////
   // Control path

   stream_fifo #(.DEPTH_LOG2(CTRL_FIFO_LOG2)) ctrl_fifo_i (
      .clk(clk), .rst_i(rst_i),
      .in_data_i(ctrl_data_i), .in_valid_i(ctrl_valid_i), .in_ready_o(ctrl_ready_o),
      .out_data_o(ctrl_int_data), .out_valid_o(ctrl_int_valid), .out_ready_i(ctrl_int_ready)
   );

   ctrl_packet_engine engine_i (
      .clk(clk), .rst_i(rst_i),
      .in_data_i(ctrl_int_data), .in_valid_i(ctrl_int_valid), .in_ready_o(ctrl_int_ready),
      .out_data_o(resp_int_data), .out_valid_o(resp_int_valid), .out_ready_i(resp_int_ready),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .rb_sel_o(rb_sel), .rb_data_i(rb_data)
   );

   stream_fifo #(.DEPTH_LOG2(RESP_FIFO_LOG2)) resp_fifo_i (
      .clk(clk), .rst_i(rst_i),
      .in_data_i(resp_int_data), .in_valid_i(resp_int_valid), .in_ready_o(resp_int_ready),
      .out_data_o(resp_data_o), .out_valid_o(resp_valid_o), .out_ready_i(resp_ready_i)
   );

   ////////////////////
   // Settings targets

   core_registers #(.BASE(SR_MISC)) core_regs_i (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .rb_sel_i(rb_sel), .rb_data_o(rb_data),
      .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .gpio_readback_i(gpio_readback), .pps_i(pps_i), .clock_sync_o(clock_sync_o)
   );

   time_64bit #(.BASE(SR_TIME64)) time_i (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps)
   );

   gpio_atr #(.BASE(SR_GPIO), .GPIO_WIDTH(GPIO_WIDTH)) gpio_i_atr (
      .clk(clk), .rst_i(rst_i),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .rx_run_i(rx_run_i), .tx_run_i(tx_run_i),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o),
      .gpio_readback_o(gpio_readback)
   );

endmodule

/* verification/radio_ctrl_core_assertions.sv */
`timescale 1ns/1ns

module radio_ctrl_core_assertions #(
   parameter int GPIO_WIDTH = 32
) (
   input logic                         clk,
   input logic                         rst_i,
   input radio_ctrl_pkg::stream_word_t resp_data_i,
   input logic                         resp_valid_i,
   input logic                         resp_ready_i,
   input logic                         set_stb_i,
   input logic [GPIO_WIDTH-1:0]        gpio_oe_i
);

   ////////////////////
   // Reply stream

   // Stalled word waits for the host
   property resp_holds_while_stalled;
      @(posedge clk) disable iff (rst_i)
         (resp_valid_i && !resp_ready_i) |=> (resp_valid_i && $stable(resp_data_i));
   endproperty

   resp_hold_a: assert property (resp_holds_while_stalled)
      else $error("resp stream changed while stalled");

   ////////////////////
   // Settings bus

   property strobe_single_cycle;
      @(posedge clk) disable iff (rst_i)
         set_stb_i |=> !set_stb_i;
   endproperty

   strobe_pulse_a: assert property (strobe_single_cycle)
      else $error("set_stb high for two cycles in a row");

   // Outputs quiet right after a reset cycle
   property reset_outputs_low;
      @(posedge clk) rst_i |=> (!resp_valid_i && !set_stb_i && gpio_oe_i == '0);
   endproperty

   reset_state_a: assert property (reset_outputs_low)
      else $error("resp valid, set_stb or gpio_oe not low after reset");

endmodule

bind radio_ctrl_core radio_ctrl_core_assertions #(.GPIO_WIDTH(GPIO_WIDTH)) assertions_i (
   .clk(clk), .rst_i(rst_i),
   .resp_data_i(resp_data_o), .resp_valid_i(resp_valid_o), .resp_ready_i(resp_ready_i),
   .set_stb_i(set_stb), .gpio_oe_i(gpio_oe_o)
);

/* verification/radio_ctrl_core_tb.sv */
`timescale 1ns/1ns

module radio_ctrl_core_tb;
   import radio_ctrl_pkg::*;

   localparam int GPIO_WIDTH  = 32;
   localparam int SEED        = 83578;
   // Long enough for a stall to fill the reply FIFO and hold the engine
   localparam int MAX_STALL   = 80;
   localparam int NUM_PACKETS = 69;
   // Per packet an engine pass plus a full stall on each reply word
   localparam int CYCLE_LIMIT = NUM_PACKETS * (12 + 2 * MAX_STALL) + 500;
   localparam set_data_t COMPAT_WORD = {16'd11, 16'd0};

   typedef logic [GPIO_WIDTH-1:0] gpio_word_t;

   logic         clk;
   logic         rst_i;
   stream_word_t ctrl_data_i;
   logic         ctrl_valid_i;
   logic         ctrl_ready_o;
   stream_word_t resp_data_o;
   logic         resp_valid_o;
   logic         resp_ready_i;
   logic         pps_i;
   logic         rx_run_i;
   logic         tx_run_i;
   gpio_word_t   gpio_i;
   gpio_word_t   gpio_o;
   gpio_word_t   gpio_oe_o;
   logic         clock_sync_o;

   // Register model
   set_data_t    model_cfg0;
   set_data_t    model_cfg1;
   set_data_t    model_time_hi;
   vita_time_t   model_pps;
   gpio_word_t   model_gpio_in;

   stream_word_t exp_hdr_q [$];
   set_data_t    exp_data_q [$];
   bit           exp_exact_q [$];
   stream_word_t got_q [$];
   set_data_t    time_rb_q [$];

   bit           stall_en = 1'b0;
   int unsigned  seed_value;
   int           cycle_count = 0;
   int           error_count = 0;
   int           check_count = 0;
   int           test_count = 0;
   int           test_errors_start = 0;
   int           reply_count = 0;

   radio_ctrl_core #(
      .GPIO_WIDTH(GPIO_WIDTH), .CTRL_FIFO_LOG2(4), .RESP_FIFO_LOG2(4)
   ) dut_i (
      .clk(clk), .rst_i(rst_i),
      .ctrl_data_i(ctrl_data_i), .ctrl_valid_i(ctrl_valid_i), .ctrl_ready_o(ctrl_ready_o),
      .resp_data_o(resp_data_o), .resp_valid_o(resp_valid_o), .resp_ready_i(resp_ready_i),
      .pps_i(pps_i), .rx_run_i(rx_run_i), .tx_run_i(tx_run_i),
      .gpio_i(gpio_i), .gpio_o(gpio_o), .gpio_oe_o(gpio_oe_o), .clock_sync_o(clock_sync_o)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: replies still missing after %0d cycles", CYCLE_LIMIT);
         $display("Verification failed");
         $finish;
      end
   end

   ////////////////////
   // Compare tasks

   task automatic compare_data(input string name, input set_data_t exp, input set_data_t got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_word(input string name, input stream_word_t exp,
                               input stream_word_t got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_gpio(input string name, input gpio_word_t exp, input gpio_word_t got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, got);
      end
   endtask

   task automatic compare_bit(input string name, input logic exp, input logic got);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, got);
      end
   endtask

   ////////////////////
   // Model and driver

   function automatic set_data_t ref_readback(input rb_sel_t idx);
      case (idx)
         RB_COMPAT:  ref_readback = COMPAT_WORD;
         RB_GPIO:    ref_readback = set_data_t'(model_gpio_in);
         RB_CONFIG0: ref_readback = model_cfg0;
         RB_CONFIG1: ref_readback = model_cfg1;
         RB_PPS_HI:  ref_readback = model_pps[63:32];
         RB_PPS_LO:  ref_readback = model_pps[31:0];
         // Running time is range checked by its test
         RB_TIME_HI: ref_readback = '0;
         RB_TIME_LO: ref_readback = '0;
         default:    ref_readback = 32'hffff_ffff;
      endcase
   endfunction

   task automatic model_write(input set_addr_t addr, input set_data_t data);
      case (addr)
         SR_MISC:            model_cfg0 = data;
         SR_MISC + 8'd1:     model_cfg1 = data;
         SR_TIME64:          model_time_hi = data;
         SR_TIME64 + 8'd2:   model_pps = {model_time_hi, data};
         default: ;
      endcase
   endtask

   // Next drive point 5 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #5;
   endtask

   task automatic push_word(input stream_word_t word);
      ctrl_data_i  = word;
      ctrl_valid_i = 1'b1;
      @(negedge clk);
      while (!ctrl_ready_o) begin
         @(negedge clk);
      end
      step();
      ctrl_valid_i = 1'b0;
   endtask

   task automatic send_command(input bit write, input rb_sel_t idx, input set_addr_t addr,
                               input set_data_t data);
      logic [7:0] seq;
      seq = 8'($urandom);
      if (write) begin
         model_write(addr, data);
      end
      exp_hdr_q.push_back({4'b0001, 8'h00, seq, 4'h0, idx, 8'h00});
      exp_data_q.push_back(ref_readback(idx));
      exp_exact_q.push_back(idx != RB_TIME_HI && idx != RB_TIME_LO);
      push_word({4'b0001, write, 7'h00, seq, 4'h0, idx, addr});
      push_word({4'b0010, data});
   endtask

   task automatic wait_replies();
      do begin
         step();
      end while (exp_hdr_q.size() != 0);
   endtask

   task automatic apply_reset();
      rst_i = 1'b1;
      repeat (3) step();
      rst_i = 1'b0;
   endtask

   task automatic pps_probe(input logic level, input logic exp);
      pps_i = level;
      @(negedge clk);
      compare_bit("clock_sync_o", exp, clock_sync_o);
      step();
   endtask

   task automatic finish_test(input string name);
      test_count++;
      $display("Test %0d, %s: %0d errors", test_count, name, error_count - test_errors_start);
      test_errors_start = error_count;
   endtask

   ////////////////////
   // Reply side

   initial begin
      int stall_len;
      resp_ready_i = 1'b1;
      forever begin
         step();
         if (stall_en && $urandom_range(3, 0) == 0) begin
            resp_ready_i = 1'b0;
            stall_len    = $urandom_range(MAX_STALL, 1);
            repeat (stall_len) step();
         end
         resp_ready_i = 1'b1;
      end
   end

   // Handshake state is settled by the falling edge
   always @(negedge clk) begin
      if (resp_valid_o && resp_ready_i) begin
         got_q.push_back(resp_data_o);
      end
   end

   initial begin
      stream_word_t hdr;
      stream_word_t dat;
      set_data_t    exp_data;
      bit           exact;
      forever begin
         @(posedge clk);
         while (got_q.size() >= 2) begin
            hdr = got_q.pop_front();
            dat = got_q.pop_front();
            reply_count++;
            if (exp_hdr_q.size() == 0) begin
               error_count++;
               $display("Reply at %0t arrived with no command outstanding", $time);
            end else begin
               exp_data = exp_data_q.pop_front();
               exact    = exp_exact_q.pop_front();
               compare_word("resp_data_o header", exp_hdr_q.pop_front(), hdr);
               compare_bit("resp_data_o eop", 1'b1, dat[33]);
               compare_bit("resp_data_o sop", 1'b0, dat[32]);
               if (exact) begin
                  compare_data("resp_data_o readback", exp_data, dat[31:0]);
               end else begin
                  time_rb_q.push_back(dat[31:0]);
               end
            end
         end
      end
   end

   ////////////////////
   // Tests

   initial begin
      gpio_word_t gpio_words [4];
      gpio_word_t gpio_dir;
      set_data_t  time_hi;
      set_data_t  time_lo;
      set_data_t  got_hi;
      set_data_t  got_lo;
      int         reply_base;
      int         pick;

      seed_value   = $urandom(SEED);
      rst_i        = 1'b1;
      ctrl_data_i  = '0;
      ctrl_valid_i = 1'b0;
      pps_i        = 1'b0;
      rx_run_i     = 1'b0;
      tx_run_i     = 1'b0;
      gpio_i       = '0;
      repeat (3) @(posedge clk);
      #5;
      rst_i = 1'b0;
      @(negedge clk);
      compare_bit("ctrl_ready_o", 1'b0, ctrl_ready_o);
      step();
      @(negedge clk);
      compare_bit("ctrl_ready_o", 1'b1, ctrl_ready_o);
      compare_bit("resp_valid_o", 1'b0, resp_valid_o);
      compare_bit("clock_sync_o", 1'b0, clock_sync_o);
      compare_gpio("gpio_oe_o", '0, gpio_oe_o);
      step();
      finish_test("reset values");

      send_command(1'b0, RB_COMPAT, 8'hff, $urandom);
      send_command(1'b0, rb_sel_t'(8 + $urandom_range(7, 0)), 8'hff, $urandom);
      send_command(1'b0, RB_COMPAT, 8'hff, $urandom);
      wait_replies();
      finish_test("compat and unused readback");

      send_command(1'b1, RB_CONFIG0, SR_MISC, $urandom);
      send_command(1'b1, RB_CONFIG1, SR_MISC + 8'd1, $urandom);
      wait_replies();
      apply_reset();
      send_command(1'b0, RB_CONFIG0, 8'hff, '0);
      send_command(1'b0, RB_CONFIG1, 8'hff, '0);
      wait_replies();
      finish_test("config words across reset");

      gpio_i        = gpio_word_t'($urandom);
      model_gpio_in = gpio_i;
      for (int k = 0; k < 4; k++) begin
         gpio_words[k] = gpio_word_t'($urandom);
         send_command(1'b1, RB_GPIO, SR_GPIO + set_addr_t'(k), gpio_words[k]);
      end
      gpio_dir = gpio_word_t'($urandom);
      send_command(1'b1, RB_GPIO, SR_GPIO + 8'd4, gpio_dir);
      wait_replies();
      @(negedge clk);
      compare_gpio("gpio_oe_o", gpio_dir, gpio_oe_o);
      // Word offset follows {tx, rx}
      for (int s = 0; s < 4; s++) begin
         step();
         rx_run_i = s[0];
         tx_run_i = s[1];
         @(posedge clk);
         @(negedge clk);
         compare_gpio("gpio_o", gpio_words[s], gpio_o);
      end
      step();
      rx_run_i = 1'b0;
      tx_run_i = 1'b0;
      finish_test("gpio atr states");

      send_command(1'b1, RB_COMPAT, SR_MISC + 8'd2, 32'd1);
      wait_replies();
      pps_probe(1'b1, 1'b1);
      pps_probe(1'b0, 1'b0);
      send_command(1'b1, RB_COMPAT, SR_MISC + 8'd2, 32'd3);
      wait_replies();
      pps_probe(1'b1, 1'b0);
      pps_probe(1'b0, 1'b1);
      send_command(1'b1, RB_COMPAT, SR_MISC + 8'd2, 32'd0);
      wait_replies();
      pps_probe(1'b1, 1'b0);
      pps_probe(1'b0, 1'b0);
      finish_test("clock sync output");

      time_hi = $urandom;
      time_lo = 32'h1000_0000 + $urandom_range(32'h00ff_ffff, 0);
      send_command(1'b1, RB_COMPAT, SR_TIME64, time_hi);
      send_command(1'b1, RB_COMPAT, SR_TIME64 + 8'd2, time_lo);
      wait_replies();
      pps_i = 1'b1;
      repeat (4) step();
      pps_i = 1'b0;
      repeat (4) step();
      send_command(1'b0, RB_PPS_HI, 8'hff, '0);
      send_command(1'b0, RB_PPS_LO, 8'hff, '0);
      send_command(1'b0, RB_TIME_HI, 8'hff, '0);
      send_command(1'b0, RB_TIME_LO, 8'hff, '0);
      wait_replies();
      if (time_rb_q.size() != 2) begin
         error_count++;
         $display("Expected two time readbacks, collected %0d", time_rb_q.size());
      end else begin
         got_hi = time_rb_q.pop_front();
         got_lo = time_rb_q.pop_front();
         compare_data("time high half", time_hi, got_hi);
         check_count++;
         if (got_lo <= time_lo) begin
            error_count++;
            $display("Time low half %h did not move past loaded value %h", got_lo, time_lo);
         end
      end
      finish_test("time load at pps");

      stall_en   = 1'b1;
      reply_base = reply_count;
      for (int n = 0; n < 48; n++) begin
         pick = $urandom_range(2, 0);
         if (pick == 0) begin
            send_command(1'b1, RB_CONFIG0, SR_MISC, $urandom);
         end else if (pick == 1) begin
            send_command(1'b0, RB_CONFIG1, 8'hff, $urandom);
         end else begin
            send_command(1'b0, RB_COMPAT, 8'hff, $urandom);
         end
      end
      wait_replies();
      stall_en = 1'b0;
      repeat (4 + MAX_STALL) step();
      check_count++;
      if (reply_count - reply_base != 48 || got_q.size() != 0) begin
         error_count++;
         $display("Back-pressure run gave %0d replies for 48 commands",
                  reply_count - reply_base);
      end
      finish_test("reply back-pressure");

      $display("Tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
      if (error_count == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* radio_ctrl_core.f */
src/radio_ctrl_pkg.sv
src/stream_fifo.sv
src/ctrl_packet_engine.sv
src/core_registers.sv
src/time_64bit.sv
src/gpio_atr.sv
src/radio_ctrl_core.sv
verification/radio_ctrl_core_assertions.sv
verification/radio_ctrl_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= radio_ctrl_core_tb
FILELIST  ?= radio_ctrl_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
